/* tests/conv1x1_golden.txt */
# Sections W weights, P pixels, E expected results, one signed Q8.8 hex value per line
# Run A is W, P, E; run B is W, E and reuses P; weights are out channel outer, in inner
# Run A weights
W
0100
0000
0000
0000
0080
0080
0080
0080
FF00
0200
0040
FF80
0000
FF40
0100
0200
# Four pixels of four channels
P
0100
0200
FF00
0080
0040
FE00
0300
0180
FF80
0400
0100
FF00
0280
0000
FD00
00C0
# Run A results, pixel outer, out channel inner
E
0100
0140
0280
FE80
0040
0160
FBC0
0780
FF80
01C0
0940
FC00
0280
0020
FC60
FE80
# Run B weights, tiny and large values
W
0200
0100
0000
0000
0000
0000
FE00
0400
0001
0000
0000
0000
6400
0000
0000
0000
# Run B results, floor and wrap cases
E
0400
0400
0001
6400
FE80
0000
0000
1900
0300
FA00
FFFF
CE00
0500
0900
0002
FA00

/* sim.f */
hdl/conv1x1_pkg.sv
hdl/replay_if.sv
hdl/pixel_replay.sv
hdl/weight_mult.sv
hdl/channel_accum.sv
hdl/align_fifo.sv
hdl/conv1x1_layer.sv
tests/tb_conv1x1_layer.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_conv1x1_layer
FILELIST  = sim.f

SOURCES   = $(shell cat $(FILELIST))
BIN       = obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

/* tests/tb_conv1x1_layer.sv */
`timescale 1ns/1ps

module tb_conv1x1_layer;
  import conv1x1_pkg::*;

  localparam int    RESET_CYCLES  = 16;
  localparam int    GROUP_SPACING = 20;
  localparam int    DRAIN_CYCLES  = 60;
  localparam int    RESULTS       = IMAGE_SIZE * CH_OUT;
  localparam int    PIXEL_VALUES  = IMAGE_SIZE * CH_IN;
  // Pixel groups whose results fill the output buffer
  localparam int    FILL_GROUPS   = ALIGN_DEPTH / CH_OUT;
  // Stray weights that move the table pointer off entry 0
  localparam int    PTR_OFFSET    = 3;
  // Reset, weight load, pixel groups, last replay and drain window
  localparam int    RUN_CYCLES    = RESET_CYCLES + WEIGHT_NUM + IMAGE_SIZE * GROUP_SPACING +
                                    PIXEL_PERIOD + DRAIN_CYCLES;
  // Two runs, about 2.5x margin
  localparam int    MAX_CYCLES    = 5 * RUN_CYCLES + 60;
  localparam string GOLDEN_FILE   = "tests/conv1x1_golden.txt";

  logic                  clk;
  logic                  reset;
  logic                  valid_weight_in;
  logic [DATA_WIDTH-1:0] weight_in;
  logic                  valid_in;
  logic [DATA_WIDTH-1:0] pxl_in;
  logic [DATA_WIDTH-1:0] pxl_out;
  logic                  valid_out;

  // Golden data, index 0 is run A
  logic [DATA_WIDTH-1:0] weights  [2][WEIGHT_NUM];
  logic [DATA_WIDTH-1:0] pixels   [PIXEL_VALUES];
  logic [DATA_WIDTH-1:0] expected [2][RESULTS];

  int cycle_cnt;
  int run;
  int rcv_cnt;
  int quiet_errs;
  int value_errs;
  int count_errs;
  int tests_run;
  int tests_failed;
  int total_errs;
  bit quiet;
  bit golden_ok;

  conv1x1_layer i_conv1x1_layer (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .valid_in        (valid_in),
    .pxl_in          (pxl_in),
    .pxl_out         (pxl_out),
    .valid_out       (valid_out)
  );

  always #5 clk = ~clk;

  function automatic string run_label(input int r);
    return (r == 0) ? "A" : "B";
  endfunction

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Testbench failed");
    $finish;
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      stop_with_failure($sformatf("Timeout after %0d cycles, results did not arrive",
                                  MAX_CYCLES));
    end
  end

  ////////////////////////////////////////
  // Output monitor
  ////////////////////////////////////////

  // Sampled mid-cycle, away from the edge
  always @(negedge clk) begin
    if (quiet) begin
      if (valid_out !== 1'b0) begin
        quiet_errs = quiet_errs + 1;
        $display("error at %0t: valid_out is %b while no output is due", $time, valid_out);
      end
    end else if (valid_out === 1'b1) begin
      if (rcv_cnt < RESULTS) begin
        // Pixel rcv_cnt/4, output channel rcv_cnt%4
        if (pxl_out !== expected[run][rcv_cnt]) begin
          value_errs = value_errs + 1;
          $display("error at %0t: run %s result %0d got %h expected %h", $time,
                   run_label(run), rcv_cnt, pxl_out, expected[run][rcv_cnt]);
        end
      end else begin
        $display("Run %s gave an extra result %h after all %0d were received",
                 run_label(run), pxl_out, RESULTS);
      end
      rcv_cnt = rcv_cnt + 1;
    end
  end

  ////////////////////////////////////////
  // Golden file
  ////////////////////////////////////////

  task automatic read_golden(output bit ok);
    int                    fd;
    int                    n;
    int                    sect;
    int                    cnt [5];
    string                 text_line;
    string                 tok;
    string                 order;
    logic [DATA_WIDTH-1:0] val;
    ok    = 1'b1;
    // Section sequence of both runs
    order = "WPEWE";
    sect  = -1;
    foreach (cnt[i]) cnt[i] = 0;
    fd = $fopen(GOLDEN_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open golden file %s", GOLDEN_FILE);
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        text_line = "";
        tok       = "";
        n = $fgets(text_line, fd);
        n = $sscanf(text_line, "%s", tok);
        // Blank and comment lines skipped
        if (n == 1 && tok.getc(0) != "#") begin
          if (tok == "W" || tok == "P" || tok == "E") begin
            sect = sect + 1;
            if (sect >= 5 || tok.getc(0) != order.getc(sect)) begin
              $display("Golden file has section %s out of order", tok);
              ok = 1'b0;
            end
          end else if (sect < 0 || sect >= 5) begin
            $display("Golden file has value %s outside any section", tok);
            ok = 1'b0;
          end else if ($sscanf(tok, "%h", val) != 1) begin
            $display("Golden file holds a bad value %s", tok);
            ok = 1'b0;
          end else begin
            case (sect)
              0: if (cnt[0] < WEIGHT_NUM) weights[0][cnt[0]] = val;
              1: if (cnt[1] < PIXEL_VALUES) pixels[cnt[1]] = val;
              2: if (cnt[2] < RESULTS) expected[0][cnt[2]] = val;
              3: if (cnt[3] < WEIGHT_NUM) weights[1][cnt[3]] = val;
              default: if (cnt[4] < RESULTS) expected[1][cnt[4]] = val;
            endcase
            cnt[sect] = cnt[sect] + 1;
          end
        end
      end
      $fclose(fd);
      if (cnt[0] != WEIGHT_NUM || cnt[1] != PIXEL_VALUES || cnt[2] != RESULTS ||
          cnt[3] != WEIGHT_NUM || cnt[4] != RESULTS) begin
        $display("Golden file section sizes are wrong: %0d %0d %0d %0d %0d",
                 cnt[0], cnt[1], cnt[2], cnt[3], cnt[4]);
        ok = 1'b0;
      end
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // All drive tasks start and end on a rising edge
  task automatic apply_reset();
    reset <= 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  endtask

  // One weight per cycle, first num entries of run r's table
  task automatic load_weights(input int r, input int num);
    for (int i = 0; i < num; i++) begin
      valid_weight_in <= 1'b1;
      weight_in       <= weights[r][i];
      @(posedge clk);
    end
    valid_weight_in <= 1'b0;
    weight_in       <= '0;
  endtask

  // Groups of CH_IN beats, GROUP_SPACING start to start
  task automatic send_pixels();
    for (int g = 0; g < IMAGE_SIZE; g++) begin
      for (int c = 0; c < CH_IN; c++) begin
        valid_in <= 1'b1;
        pxl_in   <= pixels[g * CH_IN + c];
        @(posedge clk);
      end
      valid_in <= 1'b0;
      pxl_in   <= '0;
      // Buffer cannot fill before this group is in
      if (g == FILL_GROUPS - 1) begin
        quiet = 1'b0;
      end
      repeat (GROUP_SPACING - CH_IN) @(posedge clk);
    end
  endtask

  task automatic report_test(input string name, input int errs);
    tests_run  = tests_run + 1;
    total_errs = total_errs + errs;
    if (errs == 0) begin
      $display("Test %s: ok", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %s: FAILED with %0d errors", name, errs);
    end
  endtask

  // Reset, weights, pixels, results, drain window
  task automatic run_layer(input int r);
    quiet      = 1'b1;
    run        = r;
    rcv_cnt    = 0;
    quiet_errs = 0;
    value_errs = 0;
    count_errs = 0;
    // Pointer left off entry 0, reset must bring it back
    if (r > 0) begin
      load_weights(r, PTR_OFFSET);
    end
    apply_reset();
    load_weights(r, WEIGHT_NUM);
    // No output is due until the buffer has filled once
    send_pixels();
    report_test({"no output before buffer fills, run ", run_label(r)}, quiet_errs);
    while (rcv_cnt < RESULTS) @(posedge clk);
    report_test({"result values, run ", run_label(r)}, value_errs);
    repeat (DRAIN_CYCLES) @(posedge clk);
    if (rcv_cnt != RESULTS) begin
      count_errs = count_errs + 1;
      $display("Run %s delivered %0d results where %0d were due",
               run_label(r), rcv_cnt, RESULTS);
    end
    report_test({"result count, run ", run_label(r)}, count_errs);
  endtask

  initial begin
    clk             = 1'b0;
    reset           = 1'b1;
    valid_weight_in = 1'b0;
    weight_in       = '0;
    valid_in        = 1'b0;
    pxl_in          = '0;
    cycle_cnt       = 0;
    run             = 0;
    rcv_cnt         = 0;
    quiet_errs      = 0;
    value_errs      = 0;
    count_errs      = 0;
    tests_run       = 0;
    tests_failed    = 0;
    total_errs      = 0;
    quiet           = 1'b1;
    read_golden(golden_ok);
    if (!golden_ok) begin
      stop_with_failure("Golden file could not be used, no test was run");
    end else begin
      run_layer(0);
      // Second run reloads weights over the old table
      run_layer(1);
      $display("Summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed,
               total_errs);
      if (tests_failed == 0) begin
        $display("Testbench passed");
      end else begin
        $display("Testbench failed");
      end
      $finish;
    end
  end

endmodule

/* hdl/conv1x1_layer.sv */
`timescale 1ns/1ps

module conv1x1_layer (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               valid_weight_in,
  input  logic [conv1x1_pkg::DATA_WIDTH-1:0] weight_in,
  input  logic                               valid_in,
  input  logic [conv1x1_pkg::DATA_WIDTH-1:0] pxl_in,
  output logic [conv1x1_pkg::DATA_WIDTH-1:0] pxl_out,
  output logic                               valid_out
);
  import conv1x1_pkg::*;

  // Replay beats to the multiplier
  replay_if rp_bus ();

  // Products
  logic                         prod_valid;
  logic                         prod_last;
  logic signed [PROD_WIDTH-1:0] prod;

  // Per output channel sums
  logic                         sum_valid;
  logic        [DATA_WIDTH-1:0] sum;

  pixel_replay i_pixel_replay (
    .clk      (clk),
    .reset    (reset),
    .valid_in (valid_in),
    .pxl_in   (pxl_in),
    .rp       (rp_bus.src)
  );

  weight_mult i_weight_mult (
    .clk             (clk),
    .reset           (reset),
    .valid_weight_in (valid_weight_in),
    .weight_in       (weight_in),
    .rp              (rp_bus.dst),
    .prod_valid      (prod_valid),
    .prod_last       (prod_last),
    .prod            (prod)
  );

  channel_accum i_channel_accum (
    .clk        (clk),
    .reset      (reset),
    .prod_valid (prod_valid),
    .prod_last  (prod_last),
    .prod       (prod),
    .sum_valid  (sum_valid),
    .sum        (sum)
  );

  // Holds results until the buffer fills once
  align_fifo i_align_fifo (
    .clk       (clk),
    .reset     (reset),
    .sum_valid (sum_valid),
    .sum       (sum),
    .pxl_out   (pxl_out),
    .valid_out (valid_out)
  );

endmodule

/* hdl/align_fifo.sv */
`timescale 1ns/1ps

module align_fifo (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               sum_valid,
  input  logic [conv1x1_pkg::DATA_WIDTH-1:0] sum,
  output logic [conv1x1_pkg::DATA_WIDTH-1:0] pxl_out,
  output logic                               valid_out
);
  import conv1x1_pkg::*;

  logic [DATA_WIDTH-1:0]      mem [ALIGN_DEPTH];
  logic [ALIGN_PTR_WIDTH-1:0] wr_ptr;
  logic [ALIGN_PTR_WIDTH-1:0] rd_ptr;
  logic [ALIGN_CNT_WIDTH-1:0] count;
  logic                       full;
  logic                       empty;
  logic                       rd_en;
  logic                       push;
  logic                       pop;

  assign full  = (count == ALIGN_CNT_WIDTH'(ALIGN_DEPTH));
  assign empty = (count == '0);
  assign pop   = rd_en && !empty;
  // Drop only if full with no read
  assign push  = sum_valid && (!full || pop);

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= sum;
    end
  end

  // Power-of-two depth, pointers wrap
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop)  rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  ////////////////////////////////////////
  // Read start and output
  ////////////////////////////////////////

  // Sticky once full
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_en     <= 1'b0;
      valid_out <= 1'b0;
    end else begin
      if (full) rd_en <= 1'b1;
      valid_out <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      pxl_out <= mem[rd_ptr];
    end
  end

endmodule

/* hdl/channel_accum.sv */
`timescale 1ns/1ps

module channel_accum (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      prod_valid,
  input  logic                                      prod_last,
  input  logic signed [conv1x1_pkg::PROD_WIDTH-1:0] prod,
  output logic                                      sum_valid,
  output logic        [conv1x1_pkg::DATA_WIDTH-1:0] sum
);
  import conv1x1_pkg::*;

  // Running sum, wraps on overflow
  logic signed [PROD_WIDTH-1:0] acc;
  logic signed [PROD_WIDTH-1:0] acc_next;
  logic signed [PROD_WIDTH-1:0] scaled;

  assign acc_next = acc + prod;
  // Back to Q8.8, arithmetic shift
  assign scaled   = acc_next >>> FRAC_BITS;

  always_ff @(posedge clk) begin
    if (reset) begin
      acc       <= '0;
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= prod_valid && prod_last;
      if (prod_valid) begin
        // Restart after the last input channel
        acc <= prod_last ? '0 : acc_next;
      end
    end
  end

  // Truncate to data width
  always_ff @(posedge clk) begin
    if (prod_valid && prod_last) begin
      sum <= scaled[DATA_WIDTH-1:0];
    end
  end

endmodule

/* hdl/weight_mult.sv */
`timescale 1ns/1ps

module weight_mult (
  input  logic                                      clk,
  input  logic                                      reset,
  input  logic                                      valid_weight_in,
  input  logic        [conv1x1_pkg::DATA_WIDTH-1:0] weight_in,
  replay_if.dst                                     rp,
  output logic                                      prod_valid,
  output logic                                      prod_last,
  output logic signed [conv1x1_pkg::PROD_WIDTH-1:0] prod
);
  import conv1x1_pkg::*;

  // Weight table, out_ch * CH_IN + in_ch
  logic signed [DATA_WIDTH-1:0] w_table [WEIGHT_NUM];
  logic        [WPTR_WIDTH-1:0] w_ptr;
  logic        [WPTR_WIDTH-1:0] rd_addr;
  logic signed [DATA_WIDTH-1:0] w_sel;
  logic signed [PROD_WIDTH-1:0] mult;

  ////////////////////////////////////////
  // Weight load
  ////////////////////////////////////////

  // Table contents survive reset
  always_ff @(posedge clk) begin
    if (valid_weight_in) begin
      w_table[w_ptr] <= weight_in;
    end
  end

  // Pointer restarts at entry 0
  always_ff @(posedge clk) begin
    if (reset) begin
      w_ptr <= '0;
    end else if (valid_weight_in) begin
      if (w_ptr == WPTR_WIDTH'(WEIGHT_NUM - 1)) begin
        w_ptr <= '0;
      end else begin
        w_ptr <= w_ptr + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Multiply
  ////////////////////////////////////////

  assign rd_addr = WPTR_WIDTH'(rp.out_ch * CH_IN + rp.in_ch);
  assign w_sel   = w_table[rd_addr];
  // Both operands signed, extended to full width
  assign mult    = rp.pxl * w_sel;

  always_ff @(posedge clk) begin
    prod <= mult;
  end

  // Strobes follow beat by one cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      prod_valid <= 1'b0;
      prod_last  <= 1'b0;
    end else begin
      prod_valid <= rp.valid;
      prod_last  <= rp.valid && rp.last_in;
    end
  end

endmodule

/* hdl/pixel_replay.sv */
`timescale 1ns/1ps

module pixel_replay (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               valid_in,
  input  logic [conv1x1_pkg::DATA_WIDTH-1:0] pxl_in,
  replay_if.src                              rp
);
  import conv1x1_pkg::*;

  // Capture side
  logic [DATA_WIDTH-1:0]   cap_bank [CH_IN];
  logic [CH_IDX_WIDTH-1:0] cap_cnt;
  logic                    cap_full;
  logic                    cap_last;

  // Replay side
  logic [DATA_WIDTH-1:0]   rep_bank [CH_IN];
  replay_state_t           state;
  logic [CH_IDX_WIDTH-1:0] out_cnt;
  logic [CH_IDX_WIDTH-1:0] in_cnt;
  logic                    in_wrap;
  logic                    rep_last;
  logic                    load;

  ////////////////////////////////////////
  // Capture of one pixel group
  ////////////////////////////////////////

  assign cap_last = valid_in && (cap_cnt == CH_IDX_WIDTH'(CH_IN - 1));

  always_ff @(posedge clk) begin
    if (valid_in) begin
      cap_bank[cap_cnt] <= pxl_in;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      cap_cnt  <= '0;
      cap_full <= 1'b0;
    end else begin
      if (valid_in) begin
        cap_cnt <= cap_last ? '0 : cap_cnt + 1'b1;
      end
      // New group complete
      if (cap_last) begin
        cap_full <= 1'b1;
      end else if (load) begin
        cap_full <= 1'b0;
      end
    end
  end

  ////////////////////////////////////////
  // Replay FSM
  ////////////////////////////////////////

  assign in_wrap  = (in_cnt == CH_IDX_WIDTH'(CH_IN - 1));
  assign rep_last = (state == RS_REPLAY) && in_wrap &&
                    (out_cnt == CH_IDX_WIDTH'(CH_OUT - 1));
  // Waiting group starts right after current replay
  assign load     = cap_full && ((state == RS_IDLE) || rep_last);

  always_ff @(posedge clk) begin
    if (load) begin
      rep_bank <= cap_bank;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= RS_IDLE;
      out_cnt <= '0;
      in_cnt  <= '0;
    end else begin
      case (state)
        RS_IDLE: begin
          if (load) begin
            state <= RS_REPLAY;
          end
        end
        RS_REPLAY: begin
          // Input channel inner, output channel outer
          if (in_wrap) begin
            in_cnt <= '0;
            if (rep_last) begin
              out_cnt <= '0;
              if (!load) begin
                state <= RS_IDLE;
              end
            end else begin
              out_cnt <= out_cnt + 1'b1;
            end
          end else begin
            in_cnt <= in_cnt + 1'b1;
          end
        end
        default: state <= RS_IDLE;
      endcase
    end
  end

  // Beat outputs straight from registers
  assign rp.valid   = (state == RS_REPLAY);
  assign rp.pxl     = rep_bank[in_cnt];
  assign rp.in_ch   = in_cnt;
  assign rp.out_ch  = out_cnt;
  assign rp.last_in = (state == RS_REPLAY) && in_wrap;

endmodule

/* hdl/replay_if.sv */
`timescale 1ns/1ps

interface replay_if;
  import conv1x1_pkg::*;

  // One beat per cycle while valid, no stall
  logic                         valid;
  logic signed [DATA_WIDTH-1:0] pxl;
  // Indices of the current value
  logic [CH_IDX_WIDTH-1:0]      in_ch;
  logic [CH_IDX_WIDTH-1:0]      out_ch;
  // Last input channel of this output channel
  logic                         last_in;

  modport src (output valid, pxl, in_ch, out_ch, last_in);
  modport dst (input  valid, pxl, in_ch, out_ch, last_in);

endinterface

/* hdl/conv1x1_pkg.sv */
package conv1x1_pkg;

  ////////////////////////////////////////
  // Number format
  ////////////////////////////////////////

  // Signed Q8.8 for pixels, weights and results
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 8;
  // Full product and accumulator width
  localparam int PROD_WIDTH = 32;

  ////////////////////////////////////////
  // Layer dimensions
  ////////////////////////////////////////

  localparam int CH_IN        = 4;
  localparam int CH_OUT       = 4;
  localparam int IMG_W        = 2;
  localparam int IMG_H        = 2;
  localparam int IMAGE_SIZE   = IMG_W * IMG_H;
  // Weight table, output channel outer
  localparam int WEIGHT_NUM   = CH_OUT * CH_IN;
  localparam int WPTR_WIDTH   = $clog2(WEIGHT_NUM);
  localparam int CH_IDX_WIDTH = 2;
  // Min spacing of pixel groups, start to start
  localparam int PIXEL_PERIOD = CH_IN * CH_OUT;

  // Output alignment buffer
  localparam int ALIGN_DEPTH     = 8;
  localparam int ALIGN_PTR_WIDTH = $clog2(ALIGN_DEPTH);
  localparam int ALIGN_CNT_WIDTH = $clog2(ALIGN_DEPTH + 1);

  // Replay FSM states
  typedef enum logic {
    RS_IDLE,
    RS_REPLAY
  } replay_state_t;

endpackage
